/* all.f */
+incdir+tb
logic/sq_pkg.sv
logic/sq_cdb_if.sv
logic/sq_entry.sv
logic/sq_alloc.sv
logic/sq_issue.sv
logic/store_queue.sv
tb/store_queue_tb.sv

/* logic/sq_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_alloc #(
	parameter int sq_depth = 8
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        flush,
	input  logic                        lane1_valid,
	input  logic                        lane2_valid,
	input  logic                        commit_valid,
	input  logic [sq_depth-1:0]         entry_in_use,
	input  logic [sq_depth-1:0]         entry_issued,
	output logic [sq_depth-1:0]         write,
	output logic [sq_depth-1:0]         lane_sel,
	output logic [sq_depth-1:0]         free,
	output logic [$clog2(sq_depth)-1:0] head,
	output logic [$clog2(sq_depth)-1:0] tail,
	output logic [$clog2(sq_depth):0]   free_count
);

	localparam int idx_w = $clog2(sq_depth);
	localparam int cnt_w = idx_w + 1;

	logic [idx_w-1:0] tail_plus1;
	logic [1:0]       n_disp;

	assign tail_plus1 = tail + 1'b1;
	assign n_disp     = {1'b0, lane1_valid} + {1'b0, lane2_valid};

	// Lane1 lands at the tail, lane2 right behind it
	always_comb begin
		for (int i = 0; i < sq_depth; i++) begin
			write[i]    = (lane1_valid && tail == idx_w'(i)) ||
			              (lane2_valid && tail_plus1 == idx_w'(i));
			lane_sel[i] = lane2_valid && tail_plus1 == idx_w'(i);
			free[i]     = commit_valid && head == idx_w'(i);
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head       <= '0;
			tail       <= '0;
			free_count <= cnt_w'(sq_depth);
		end else begin
			tail <= tail + idx_w'(n_disp);  // Wraps naturally, depth is a power of two
			if (commit_valid)
				head <= head + 1'b1;
			free_count <= free_count - cnt_w'(n_disp) + cnt_w'(commit_valid);
		end
	end

	// Dispatch sees last cycle's count, so it must never overrun it
	a_dispatch_room: assert property (@(posedge clock) disable iff (reset || flush)
		cnt_w'(n_disp) <= free_count)
		else $error("sq_alloc: dispatch beyond free_count");

	// ROB only commits a store that has already gone to memory
	a_commit_head: assert property (@(posedge clock) disable iff (reset || flush)
		commit_valid |-> entry_in_use[head] && entry_issued[head])
		else $error("sq_alloc: commit of a head entry not in use or not issued");

endmodule

`default_nettype wire

/* logic/sq_cdb_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface sq_cdb_if import sq_pkg::*; ();

	logic [xlen-1:0]      cdb1_value;
	logic [prf_tag_w-1:0] cdb1_tag;
	logic                 cdb1_valid;   // Valid for one cycle only
	logic [xlen-1:0]      cdb2_value;
	logic [prf_tag_w-1:0] cdb2_tag;
	logic                 cdb2_valid;

	modport broadcast (
		output cdb1_value, cdb1_tag, cdb1_valid,
		output cdb2_value, cdb2_tag, cdb2_valid
	);

	modport snoop (
		input cdb1_value, cdb1_tag, cdb1_valid,
		input cdb2_value, cdb2_tag, cdb2_valid
	);

endinterface

`default_nettype wire

/* logic/sq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_entry import sq_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic         flush,
	input  logic         write,
	input  logic         lane_sel,      // Set selects lane2
	input  sq_dispatch_t lane1,
	input  sq_dispatch_t lane2,
	input  logic         free,
	input  logic         mark_issued,
	sq_cdb_if.snoop      cdb,
	output logic         in_use,
	output logic         ready,
	output logic         issued,
	output sq_store_t    store
);

	sq_dispatch_t    sel;
	logic            offset_valid;
	logic            data_valid;
	logic            offset_hit;
	logic            data_hit;
	logic [xlen-1:0] offset_cdb;
	logic [xlen-1:0] data_cdb;

	assign sel   = lane_sel ? lane2 : lane1;
	assign ready = in_use && offset_valid && data_valid;

	// Bus 2 is checked last so it wins a tie on a tag match
	always_comb begin
		offset_hit = 1'b0;
		offset_cdb = store.offset;
		data_hit   = 1'b0;
		data_cdb   = store.data;
		if (cdb.cdb1_valid && store.offset[prf_tag_w-1:0] == cdb.cdb1_tag) begin
			offset_hit = 1'b1;
			offset_cdb = cdb.cdb1_value;
		end
		if (cdb.cdb2_valid && store.offset[prf_tag_w-1:0] == cdb.cdb2_tag) begin
			offset_hit = 1'b1;
			offset_cdb = cdb.cdb2_value;
		end
		if (cdb.cdb1_valid && store.data[prf_tag_w-1:0] == cdb.cdb1_tag) begin
			data_hit = 1'b1;
			data_cdb = cdb.cdb1_value;
		end
		if (cdb.cdb2_valid && store.data[prf_tag_w-1:0] == cdb.cdb2_tag) begin
			data_hit = 1'b1;
			data_cdb = cdb.cdb2_value;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			in_use       <= 1'b0;
			issued       <= 1'b0;
			offset_valid <= 1'b0;
			data_valid   <= 1'b0;
		end else if (write) begin
			in_use       <= 1'b1;
			issued       <= 1'b0;
			offset_valid <= sel.offset_valid;
			data_valid   <= sel.data_valid;
		end else if (free) begin
			in_use <= 1'b0;                 // Commit returns the slot to the pool
			issued <= 1'b0;
		end else if (in_use) begin
			if (!offset_valid && offset_hit)
				offset_valid <= 1'b1;
			if (!data_valid && data_hit)
				data_valid <= 1'b1;
			if (mark_issued)
				issued <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			store.base    <= sel.base;
			store.offset  <= sel.offset;
			store.data    <= sel.data;
			store.rob_idx <= sel.rob_idx;
		end else if (in_use) begin
			if (!offset_valid && offset_hit)
				store.offset <= offset_cdb;   // Wakeup of the address operand
			if (!data_valid && data_hit)
				store.data <= data_cdb;
		end
	end

	// Allocation only ever targets a free slot
	a_write_free: assert property (@(posedge clock) disable iff (reset || flush)
		write |-> !in_use)
		else $error("sq_entry: write to an entry in use");

	// Issue picks this entry once, and only after both operands have arrived
	a_issue_ready: assert property (@(posedge clock) disable iff (reset || flush)
		mark_issued |-> ready && !issued)
		else $error("sq_entry: issued while not ready or already issued");

endmodule

`default_nettype wire

/* logic/sq_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_issue import sq_pkg::*; #(
	parameter int sq_depth    = 8,
	parameter int mem_credits = 2
) (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        flush,
	input  logic [$clog2(sq_depth)-1:0] tail,
	input  logic [sq_depth-1:0]         entry_ready,
	input  logic [sq_depth-1:0]         entry_issued,
	input  sq_store_t                   entry_store [sq_depth],
	input  logic                        mem_credit_return,
	output logic [sq_depth-1:0]         mark_issued,
	output logic                        mem_req_valid,
	output logic [xlen-1:0]             mem_req_addr,
	output logic [xlen-1:0]             mem_req_data,
	output logic [rob_idx_w-1:0]        mem_req_rob_idx
);

	localparam int idx_w    = $clog2(sq_depth);
	localparam int credit_w = $clog2(mem_credits + 1);

	logic [idx_w-1:0]    issue_ptr;
	logic [credit_w-1:0] credit_cnt;
	sq_store_t           cur;
	logic                pending;
	logic                pick;

	assign cur = entry_store[issue_ptr];

	// Work left: pointer behind the tail, or a full queue whose oldest is not yet sent
	assign pending = (issue_ptr != tail) || !entry_issued[issue_ptr];
	assign pick    = pending && entry_ready[issue_ptr] && credit_cnt != '0 && !flush;

	always_comb begin
		for (int i = 0; i < sq_depth; i++)
			mark_issued[i] = pick && issue_ptr == idx_w'(i);
	end

	always_ff @(posedge clock) begin
		if (reset || flush)
			issue_ptr <= '0;
		else if (pick)
			issue_ptr <= issue_ptr + 1'b1;
	end

	// Return and request in the same cycle leave the count unchanged
	always_ff @(posedge clock) begin
		if (reset)
			credit_cnt <= credit_w'(mem_credits);
		else
			credit_cnt <= credit_cnt + credit_w'(mem_credit_return) - credit_w'(pick);
	end

	always_ff @(posedge clock) begin
		if (reset)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= pick;          // One-cycle pulse per store
	end

	always_ff @(posedge clock) begin
		if (pick) begin
			mem_req_addr    <= cur.base + cur.offset;
			mem_req_data    <= cur.data;
			mem_req_rob_idx <= cur.rob_idx;
		end
	end

	// Memory never holds more requests than it granted credits for
	a_credit_max: assert property (@(posedge clock) disable iff (reset)
		credit_cnt <= credit_w'(mem_credits))
		else $error("sq_issue: credit count above mem_credits");

	a_credit_return: assert property (@(posedge clock) disable iff (reset)
		mem_credit_return && !pick |-> credit_cnt != credit_w'(mem_credits))
		else $error("sq_issue: credit returned with no request outstanding");

endmodule

`default_nettype wire

/* logic/sq_pkg.sv */
`default_nettype none

package sq_pkg;

	// ROB index width, the top bit is the wrap bit
	localparam int rob_idx_w = 6;

	// Physical register tag width, as carried on the CDB
	localparam int prf_tag_w = 6;

	// Data and address width
	localparam int xlen = 64;

	// One store as it leaves dispatch
	typedef struct packed {
		logic [xlen-1:0]      pc;
		logic [31:0]          inst;
		logic [xlen-1:0]      base;         // Address base, always a value
		logic [xlen-1:0]      offset;       // Tag in the low bits until offset_valid
		logic                 offset_valid;
		logic [xlen-1:0]      data;         // Tag in the low bits until data_valid
		logic                 data_valid;
		logic [rob_idx_w-1:0] rob_idx;
	} sq_dispatch_t;

	// What an entry hands to the issue block
	typedef struct packed {
		logic [xlen-1:0]      base;
		logic [xlen-1:0]      offset;
		logic [xlen-1:0]      data;
		logic [rob_idx_w-1:0] rob_idx;
	} sq_store_t;

endpackage

`default_nettype wire

/* logic/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue import sq_pkg::*; #(
	parameter int sq_depth    = 8,
	parameter int mem_credits = 2
) (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      flush,
	input  logic                      lane1_valid,
	input  sq_dispatch_t              lane1,
	input  logic                      lane2_valid,
	input  sq_dispatch_t              lane2,
	input  logic [xlen-1:0]           cdb1_value,
	input  logic [prf_tag_w-1:0]      cdb1_tag,
	input  logic                      cdb1_valid,
	input  logic [xlen-1:0]           cdb2_value,
	input  logic [prf_tag_w-1:0]      cdb2_tag,
	input  logic                      cdb2_valid,
	input  logic                      commit_valid,
	input  logic                      mem_credit_return,
	output logic [$clog2(sq_depth):0] free_count,
	output logic                      mem_req_valid,
	output logic [xlen-1:0]           mem_req_addr,
	output logic [xlen-1:0]           mem_req_data,
	output logic [rob_idx_w-1:0]      mem_req_rob_idx
);

	localparam int idx_w = $clog2(sq_depth);

	logic [sq_depth-1:0] write;
	logic [sq_depth-1:0] lane_sel;
	logic [sq_depth-1:0] free;
	logic [sq_depth-1:0] mark_issued;
	logic [sq_depth-1:0] entry_in_use;
	logic [sq_depth-1:0] entry_ready;
	logic [sq_depth-1:0] entry_issued;
	logic [idx_w-1:0]    tail;
	sq_store_t           entry_store [sq_depth];

	sq_cdb_if cdb ();

	// Result buses fan out to every entry
	assign cdb.cdb1_value = cdb1_value;
	assign cdb.cdb1_tag   = cdb1_tag;
	assign cdb.cdb1_valid = cdb1_valid;
	assign cdb.cdb2_value = cdb2_value;
	assign cdb.cdb2_tag   = cdb2_tag;
	assign cdb.cdb2_valid = cdb2_valid;

	sq_alloc #(
		.sq_depth (sq_depth)
	) alloc (
		.clock        (clock),
		.reset        (reset),
		.flush        (flush),
		.lane1_valid  (lane1_valid),
		.lane2_valid  (lane2_valid),
		.commit_valid (commit_valid),
		.entry_in_use (entry_in_use),
		.entry_issued (entry_issued),
		.write        (write),
		.lane_sel     (lane_sel),
		.free         (free),
		.head         (),
		.tail         (tail),
		.free_count   (free_count)
	);

	for (genvar i = 0; i < sq_depth; i++) begin : g_entry
		sq_entry entry (
			.clock       (clock),
			.reset       (reset),
			.flush       (flush),
			.write       (write[i]),
			.lane_sel    (lane_sel[i]),
			.lane1       (lane1),
			.lane2       (lane2),
			.free        (free[i]),
			.mark_issued (mark_issued[i]),
			.cdb         (cdb),
			.in_use      (entry_in_use[i]),
			.ready       (entry_ready[i]),
			.issued      (entry_issued[i]),
			.store       (entry_store[i])
		);
	end

	sq_issue #(
		.sq_depth    (sq_depth),
		.mem_credits (mem_credits)
	) issue (
		.clock             (clock),
		.reset             (reset),
		.flush             (flush),
		.tail              (tail),
		.entry_ready       (entry_ready),
		.entry_issued      (entry_issued),
		.entry_store       (entry_store),
		.mem_credit_return (mem_credit_return),
		.mark_issued       (mark_issued),
		.mem_req_valid     (mem_req_valid),
		.mem_req_addr      (mem_req_addr),
		.mem_req_data      (mem_req_data),
		.mem_req_rob_idx   (mem_req_rob_idx)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module store_queue_tb -Mdir obj_dir \
	&& ./obj_dir/Vstore_queue_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run.sh: pass" \
	|| { echo "run.sh: fail"; exit 1; }

/* tb/sq_tb_tasks.svh */
`ifndef SQ_TB_TASKS_SVH
`define SQ_TB_TASKS_SVH

// Xorshift32 step on the shared state
function automatic logic [31:0] xorshift32();
	rng = rng ^ (rng << 13);
	rng = rng ^ (rng >> 17);
	rng = rng ^ (rng << 5);
	return rng;
endfunction

function automatic logic [63:0] rand64();
	logic [31:0] hi;
	hi = xorshift32();
	return {hi, xorshift32()};
endfunction

// Tagged operands carry the tag in the low bits of the field
function automatic sq_dispatch_t build_store(input logic [63:0] base, input logic [63:0] offset,
		input logic offset_valid, input logic [63:0] data, input logic data_valid);
	sq_dispatch_t s;
	s              = '0;
	s.pc           = 64'h1000 + {rob_next, 2'b00};
	s.inst         = 32'h0000_3023;            // sd
	s.base         = base;
	s.offset       = offset;
	s.offset_valid = offset_valid;
	s.data         = data;
	s.data_valid   = data_valid;
	s.rob_idx      = rob_next;
	rob_next       = rob_next + 1'b1;
	return s;
endfunction

task automatic expect_store(input logic [63:0] addr, input logic [63:0] data,
		input logic [rob_idx_w-1:0] rob);
	exp_addr.push_back(addr);
	exp_data.push_back(data);
	exp_rob.push_back(rob);
endtask

// Store with both operands present, small offset
task automatic ready_store(output sq_dispatch_t s);
	logic [63:0] base;
	logic [63:0] offset;
	logic [63:0] data;
	base   = rand64();
	offset = rand64() & 64'hffff;
	data   = rand64();
	s      = build_store(base, offset, 1'b1, data, 1'b1);
	expect_store(base + offset, data, s.rob_idx);
endtask

task automatic dispatch_pair(input sq_dispatch_t s1, input sq_dispatch_t s2, input logic both);
	lane1_valid = 1'b1;
	lane1       = s1;
	lane2_valid = both;
	lane2       = s2;
	@(negedge clock);
	lane1_valid = 1'b0;
	lane2_valid = 1'b0;
endtask

task automatic broadcast(input int bus, input logic [prf_tag_w-1:0] tag, input logic [63:0] value);
	if (bus == 1) begin
		cdb1_valid = 1'b1;
		cdb1_tag   = tag;
		cdb1_value = value;
	end else begin
		cdb2_valid = 1'b1;
		cdb2_tag   = tag;
		cdb2_value = value;
	end
	@(negedge clock);
	cdb1_valid = 1'b0;
	cdb2_valid = 1'b0;
endtask

task automatic commit_stores(input int n);
	for (int i = 0; i < n; i++) begin
		commit_valid = 1'b1;
		@(negedge clock);
	end
	commit_valid = 1'b0;
endtask

task automatic return_credit();
	mem_credit_return = 1'b1;
	inflight--;
	@(negedge clock);
	mem_credit_return = 1'b0;
endtask

`endif

/* tb/store_queue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue_tb import sq_pkg::*; ();

	localparam int depth   = 8;
	localparam int credits = 2;
	localparam int timeout = 200;

	logic                 clock;
	logic                 reset;
	logic                 flush;
	logic                 lane1_valid;
	logic                 lane2_valid;
	sq_dispatch_t         lane1;
	sq_dispatch_t         lane2;
	logic [xlen-1:0]      cdb1_value;
	logic [prf_tag_w-1:0] cdb1_tag;
	logic                 cdb1_valid;
	logic [xlen-1:0]      cdb2_value;
	logic [prf_tag_w-1:0] cdb2_tag;
	logic                 cdb2_valid;
	logic                 commit_valid;
	logic                 mem_credit_return;
	logic [$clog2(depth):0] free_count;
	logic                 mem_req_valid;
	logic [xlen-1:0]      mem_req_addr;
	logic [xlen-1:0]      mem_req_data;
	logic [rob_idx_w-1:0] mem_req_rob_idx;

	logic [31:0]          rng = 32'hc4d4e541;
	logic [rob_idx_w-1:0] rob_next = '0;
	logic [63:0]          exp_addr [$];
	logic [63:0]          exp_data [$];
	logic [rob_idx_w-1:0] exp_rob [$];
	int                   req_count = 0;
	int                   inflight = 0;
	int                   errors = 0;
	int                   checks = 0;
	int                   tests = 0;
	int                   test_start_errors = 0;
	string                test_name = "reset";

	`include "sq_tb_tasks.svh"

	store_queue #(.sq_depth(depth), .mem_credits(credits)) UUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check_eq(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		assert (expected == actual)
		else begin
			$display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	// Each wait below gives up on its own after timeout cycles
	task automatic wait_requests(input int target);
		int n;
		n = 0;
		while (req_count < target && n < timeout) begin
			@(negedge clock);
			n++;
		end
		if (req_count < target) begin
			$display("%s timed out waiting for a memory request", test_name);
			errors++;
		end
	endtask

	// Returns credits until target requests arrived and none are in flight
	task automatic drain(input int target);
		int n;
		n = 0;
		while ((req_count < target || inflight > 0) && n < timeout) begin
			if (inflight > 0)
				return_credit();
			else
				@(negedge clock);
			n++;
		end
		if (req_count < target || inflight > 0) begin
			$display("%s timed out draining the memory requests", test_name);
			errors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic finish_test();
		tests++;
		$display("test %s: %0d errors", test_name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// Every request must match the oldest expected store
	always @(posedge clock) begin
		if (!reset && mem_req_valid) begin
			req_count++;
			inflight++;
			checks++;
			assert (inflight <= credits)
			else begin
				$display("%s: more requests in flight than memory credits", test_name);
				errors++;
			end
			if (exp_addr.size() == 0) begin
				$display("%s: memory request while no store was expected", test_name);
				errors++;
			end else begin
				check_eq("addr", exp_addr.pop_front(), mem_req_addr);
				check_eq("data", exp_data.pop_front(), mem_req_data);
				check_eq("rob_idx", 64'(exp_rob.pop_front()), 64'(mem_req_rob_idx));
			end
		end
	end

	initial begin
		#2_000_000;
		$display("Simulation hung, watchdog expired");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		sq_dispatch_t s1;
		sq_dispatch_t s2;
		sq_dispatch_t s3;
		int base_cnt;
		logic [63:0] b;
		logic [63:0] v;
		reset = 1'b1;
		flush = 1'b0;
		lane1_valid = 1'b0;
		lane2_valid = 1'b0;
		lane1 = '0;
		lane2 = '0;
		cdb1_value = '0;
		cdb1_tag = '0;
		cdb1_valid = 1'b0;
		cdb2_value = '0;
		cdb2_tag = '0;
		cdb2_valid = 1'b0;
		commit_valid = 1'b0;
		mem_credit_return = 1'b0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		test_name = "reset_dispatch";
		check_eq("free_count", depth, 64'(free_count));
		check_eq("mem_req_valid", 0, 64'(mem_req_valid));
		ready_store(s1);
		ready_store(s2);
		dispatch_pair(s1, s2, 1'b1);
		check_eq("free_count", depth - 2, 64'(free_count));
		drain(2);
		commit_stores(2);
		finish_test();

		test_name = "in_order";
		base_cnt = req_count;
		for (int i = 0; i < 2; i++) begin
			ready_store(s1);
			ready_store(s2);
			dispatch_pair(s1, s2, 1'b1);
		end
		drain(base_cnt + 4);
		commit_stores(4);
		finish_test();

		test_name = "cdb_wakeup";
		base_cnt = req_count;
		b = rand64();
		v = rand64();
		s1 = build_store(b, 64'h40, 1'b1, 64'd5, 1'b0);   // Data waits on tag 5
		expect_store(b + 64'h40, v, s1.rob_idx);
		ready_store(s2);
		dispatch_pair(s1, s2, 1'b1);
		idle(4);
		check_eq("requests before wakeup", base_cnt, req_count);
		broadcast(2, 6'd5, v);
		drain(base_cnt + 2);
		b = rand64();
		v = rand64() & 64'hfff;
		s3 = build_store(b, 64'd9, 1'b0, 64'hfeed, 1'b1);  // Offset waits on tag 9
		expect_store(b + v, 64'hfeed, s3.rob_idx);
		dispatch_pair(s3, s3, 1'b0);
		idle(3);
		check_eq("requests before wakeup", base_cnt + 2, req_count);
		broadcast(1, 6'd9, v);
		drain(base_cnt + 3);
		commit_stores(3);
		finish_test();

		test_name = "credits";
		base_cnt = req_count;
		for (int i = 0; i < 2; i++) begin
			ready_store(s1);
			ready_store(s2);
			dispatch_pair(s1, s2, 1'b1);
		end
		wait_requests(base_cnt + credits);
		idle(5);
		check_eq("requests at zero credit", base_cnt + credits, req_count);
		return_credit();
		wait_requests(base_cnt + credits + 1);
		idle(5);
		check_eq("requests after one return", base_cnt + credits + 1, req_count);
		drain(base_cnt + 4);
		commit_stores(4);
		finish_test();

		test_name = "fill_commit";
		base_cnt = req_count;
		v = rand64();
		for (int i = 0; i < depth / 2; i++) begin
			b = rand64();
			s1 = build_store(b, 64'h8, 1'b1, 64'd17, 1'b0);
			expect_store(b + 64'h8, v, s1.rob_idx);
			s2 = build_store(b, 64'h10, 1'b1, 64'd17, 1'b0);
			expect_store(b + 64'h10, v, s2.rob_idx);
			dispatch_pair(s1, s2, 1'b1);
		end
		check_eq("free_count full", 0, 64'(free_count));
		broadcast(1, 6'd17, v);
		drain(base_cnt + depth);
		for (int i = 1; i <= depth; i++) begin
			commit_stores(1);
			check_eq("free_count after commit", i, 64'(free_count));
		end
		finish_test();

		test_name = "flush";
		base_cnt = req_count;
		s1 = build_store(rand64(), 64'd12, 1'b0, 64'h1, 1'b1);
		s2 = build_store(rand64(), 64'd12, 1'b0, 64'h2, 1'b1);
		s3 = build_store(rand64(), 64'd12, 1'b0, 64'h3, 1'b1);
		dispatch_pair(s1, s2, 1'b1);
		dispatch_pair(s3, s3, 1'b0);
		flush = 1'b1;
		@(negedge clock);
		flush = 1'b0;
		check_eq("free_count after flush", depth, 64'(free_count));
		broadcast(1, 6'd12, 64'h100);
		idle(6);
		check_eq("requests after flush", base_cnt, req_count);
		ready_store(s1);
		ready_store(s2);
		dispatch_pair(s1, s2, 1'b1);
		drain(base_cnt + 2);
		commit_stores(2);
		check_eq("free_count", depth, 64'(free_count));
		finish_test();

		if (exp_addr.size() != 0) begin
			$display("%0d expected stores never reached memory", exp_addr.size());
			errors++;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
